// File: sources.f
+incdir+hw
hw/video_timing_pkg.sv
hw/video_pixel_pkg.sv
hw/video_timer.sv
hw/pxl_delay.sv
hw/tile_layer.sv
hw/color_mixer.sv
hw/video_top.sv
sim/video_tb.sv

// File: Makefile
# Verilator build and run for the tile video testbench

VERILATOR ?= verilator
TOP       ?= video_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/video_tb.sv
/*
  Testbench for video_top. Each table entry writes maps, scroll and palette
  during vertical blank, then checks one visible frame pixel by pixel.
  The ROM model treats pattern code 0 as a blank tile (all pens zero).
  Pixel position comes from the delayed lhbl/lvbl outputs, not from latency.
*/
`include "video_defines.svh"

module video_tb;
    import video_pixel_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_ENTRIES  = 5;
    // One frame per entry plus a spare frame of margin
    localparam longint TIMEOUT = longint'(N_ENTRIES + 1) * `H_TOTAL * `V_TOTAL * 2 * CLK_PERIOD;

    typedef enum logic [1:0] {FILL_CLEAR, FILL_RANDOM, FILL_L1} fill_e;
    typedef enum logic {PAL_RAMP, PAL_RANDOM} pal_e;

    typedef struct packed {
        logic [5:0] h0;
        logic [5:0] v0;
        logic [5:0] h1;
        logic [5:0] v1;
        fill_e      fill;
        pal_e       pal;
    } entry_t;

    entry_t stim [N_ENTRIES] = '{
        // hscroll0, vscroll0, hscroll1, vscroll1, map fill, palette
        '{6'd0,  6'd0,  6'd0,  6'd0,  FILL_RANDOM, PAL_RAMP},
        '{6'd0,  6'd0,  6'd0,  6'd0,  FILL_CLEAR,  PAL_RANDOM},
        '{6'd13, 6'd5,  6'd50, 6'd61, FILL_RANDOM, PAL_RANDOM},
        '{6'd3,  6'd40, 6'd0,  6'd9,  FILL_L1,     PAL_RAMP},
        '{6'd63, 6'd63, 6'd21, 6'd2,  FILL_RANDOM, PAL_RANDOM}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    cpu_wr_t     cpu_wr;
    gfx_req_t    gfx0_addr;
    gfx_req_t    gfx1_addr;
    logic        gfx0_cs;
    logic        gfx1_cs;
    logic [31:0] gfx0_data;
    logic [31:0] gfx1_data;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        lhbl;
    logic        lvbl;
    logic        hs;
    logic        vs;

    // Pixel enable phase as the timing rule defines it
    logic        cen_ref;
    logic [31:0] lfsr_state = 32'h5f4a_09d0;

    // Shadow copies of what the CPU has written
    logic [11:0] map_sh [2][64];
    logic [5:0]  scr_sh [4];
    logic [11:0] pal_sh [256];
    cpu_wr_t     wr_q [$];

    video_top video_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_wr    (cpu_wr),
        .gfx0_addr (gfx0_addr),
        .gfx1_addr (gfx1_addr),
        .gfx0_cs   (gfx0_cs),
        .gfx1_cs   (gfx1_cs),
        .gfx0_data (gfx0_data),
        .gfx1_data (gfx1_data),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .hs        (hs),
        .vs        (vs)
    );

    always #(CLK_PERIOD / 2) clk = !clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_ref <= 1'b0;
        end else begin
            cen_ref <= !cen_ref;
        end
    end

    task automatic check_eq(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] lfsr_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Each nibble is code + row + pixel, pixel 0 in the low nibble
    function automatic logic [31:0] rom_row(logic [7:0] code, logic [2:0] row);
        logic [31:0] r;
        r = '0;
        for (int p = 0; p < 8; p++) begin
            r[4*p +: 4] = (code == 8'd0) ? 4'd0 : 4'(code + row + p);
        end
        return r;
    endfunction

    // ROM models, data one clk after the request
    always @(posedge clk) begin
        gfx_req_t req0;
        gfx_req_t req1;
        logic     cs0;
        logic     cs1;
        req0 = gfx0_addr;
        req1 = gfx1_addr;
        cs0  = gfx0_cs;
        cs1  = gfx1_cs;
        #5;
        if (cs0) begin
            check_eq(req0.spare, 0, "layer 0 ROM address spare bit");
            gfx0_data = rom_row(req0.code, req0.row);
        end
        if (cs1) begin
            check_eq(req1.spare, 0, "layer 1 ROM address spare bit");
            gfx1_data = rom_row(req1.code, req1.row);
        end
    end

    function automatic logic [23:0] expect_rgb(int x, int y);
        logic [5:0]  sx;
        logic [5:0]  sy;
        logic [11:0] ent;
        logic [31:0] row;
        logic [3:0]  pen [2];
        logic [3:0]  pal [2];
        logic [7:0]  idx;
        logic [11:0] c;
        for (int l = 0; l < 2; l++) begin
            sx     = 6'(x + scr_sh[2*l]);
            sy     = 6'(y + scr_sh[2*l+1]);
            ent    = map_sh[l][{sy[5:3], sx[5:3]}];
            row    = rom_row(ent[7:0], sy[2:0]);
            pen[l] = row[4*sx[2:0] +: 4];
            pal[l] = ent[11:8];
        end
        if (pen[0] != 4'd0) begin
            idx = {pal[0], pen[0]};
        end else if (pen[1] != 4'd0) begin
            idx = {pal[1], pen[1]};
        end else begin
            idx = 8'd0;
        end
        c = pal_sh[idx];
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    task automatic push_write(cpu_target_e tgt, int addr, logic [15:0] data);
        wr_q.push_back(cpu_wr_t'{we: 1'b1, target: tgt, addr: 8'(addr), data: data});
    endtask

    task automatic queue_settings(entry_t t);
        logic [11:0] v;
        for (int l = 0; l < 2; l++) begin
            for (int i = 0; i < 64; i++) begin
                if (t.fill == FILL_RANDOM || (t.fill == FILL_L1 && l == 1)) begin
                    v = 12'(lfsr_bits(12));
                    // Extra blank tiles on layer 0 let layer 1 through
                    if (l == 0 && lfsr_bits(2) == 16'd0) begin
                        v[7:0] = 8'h00;
                    end
                end else begin
                    v = {4'(lfsr_bits(4)), 8'h00};
                end
                map_sh[l][i] = v;
                push_write(l == 0 ? map0 : map1, i, {4'h0, v});
            end
        end
        scr_sh[0] = t.h0;
        scr_sh[1] = t.v0;
        scr_sh[2] = t.h1;
        scr_sh[3] = t.v1;
        for (int i = 0; i < 4; i++) begin
            push_write(scroll, i, {10'h0, scr_sh[i]});
        end
        for (int i = 0; i < 256; i++) begin
            v = (t.pal == PAL_RAMP) ? {4'(i[3:0] ^ i[7:4]), 4'(i[7:4]), 4'(i[3:0])}
                                    : 12'(lfsr_bits(12));
            pal_sh[i] = v;
            push_write(palette, i, {4'h0, v});
        end
    endtask

    // Advance to the next pixel, issuing one queued CPU write per clk
    task automatic next_pixel();
        logic upd;
        upd = 1'b0;
        while (!upd) begin
            @(posedge clk);
            upd = cen_ref;
            #5;
            if (wr_q.size() > 0) begin
                cpu_wr = wr_q.pop_front();
            end else begin
                cpu_wr = '0;
            end
        end
        #5;
    endtask

    // Runs from the start of vertical blank to the end of the next visible frame
    task automatic run_entry(int e);
        int          x;
        int          y;
        int          hs_cnt;
        int          hs_px;
        int          vs_cnt;
        int          vs_px;
        logic        in_frame;
        logic        done;
        logic        prev_hbl;
        logic        prev_vbl;
        logic        prev_hs;
        logic        prev_vs;
        logic [23:0] rgb;
        x        = 0;
        y        = -1;
        hs_cnt   = 0;
        hs_px    = 0;
        vs_cnt   = 0;
        vs_px    = 0;
        in_frame = 1'b0;
        done     = 1'b0;
        prev_hbl = lhbl;
        prev_vbl = lvbl;
        prev_hs  = hs;
        prev_vs  = vs;
        queue_settings(stim[e]);
        while (!done) begin
            next_pixel();
            rgb = {red, green, blue};
            if (vs && !prev_vs) begin
                vs_cnt++;
            end
            if (vs) begin
                vs_px++;
            end
            if (lvbl && !prev_vbl) begin
                check_eq(wr_q.size(), 0, "CPU writes still pending at frame start");
                in_frame = 1'b1;
            end
            if (in_frame && !lvbl) begin
                done = 1'b1;
            end else if (in_frame) begin
                if (hs && !prev_hs) begin
                    hs_cnt++;
                end
                if (hs) begin
                    hs_px++;
                end
                if (lhbl && !prev_hbl) begin
                    y++;
                    x = 0;
                end
                if (!lhbl && prev_hbl) begin
                    check_eq(x, `H_ACTIVE,
                             $sformatf("entry %0d visible pixels in line %0d", e, y));
                end
            end
            if (lhbl && lvbl) begin
                check_eq(rgb, expect_rgb(x, y),
                         $sformatf("entry %0d rgb at x=%0d y=%0d", e, x, y));
                x++;
            end else begin
                check_eq(rgb, 0, $sformatf("entry %0d rgb during blanking", e));
            end
            prev_hbl = lhbl;
            prev_vbl = lvbl;
            prev_hs  = hs;
            prev_vs  = vs;
        end
        check_eq(y + 1, `V_ACTIVE, $sformatf("entry %0d visible lines", e));
        check_eq(hs_cnt, `V_ACTIVE, $sformatf("entry %0d hsync pulses", e));
        check_eq(hs_px, `V_ACTIVE * `HS_LEN, $sformatf("entry %0d hsync width", e));
        check_eq(vs_cnt, 1, $sformatf("entry %0d vsync pulses", e));
        check_eq(vs_px, `VS_LEN * `H_TOTAL, $sformatf("entry %0d vsync width", e));
    endtask

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before all table entries were checked");
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n     = 1'b0;
        cpu_wr    = '0;
        gfx0_data = '0;
        gfx1_data = '0;
        repeat (2) @(posedge clk);
        #5;
        check_eq({red, green, blue, lhbl, lvbl, hs, vs}, 0, "outputs during reset");
        rst_n = 1'b1;
        next_pixel();
        check_eq({red, green, blue, lhbl, lvbl, hs, vs}, 0, "outputs right after reset");
        for (int e = 0; e < N_ENTRIES; e++) begin
            run_entry(e);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: hw/video_top.sv
/*
  Timer, two tile layers and colour mixer on a single clock.
  Each layer has its own ROM port with a fixed one-clk read latency.
  lhbl, lvbl, hs and vs are delayed to line up with RGB.
*/
`include "video_defines.svh"

module video_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  video_pixel_pkg::cpu_wr_t  cpu_wr,
    output video_pixel_pkg::gfx_req_t gfx0_addr,
    output video_pixel_pkg::gfx_req_t gfx1_addr,
    output logic                      gfx0_cs,
    output logic                      gfx1_cs,
    input  logic [31:0]               gfx0_data,
    input  logic [31:0]               gfx1_data,
    output logic [7:0]                red,
    output logic [7:0]                green,
    output logic [7:0]                blue,
    output logic                      lhbl,
    output logic                      lvbl,
    output logic                      hs,
    output logic                      vs
);
    import video_timing_pkg::*;
    import video_pixel_pkg::*;

    logic       pxl_cen;
    raster_t    raster;
    layer_pxl_t pxl0;
    layer_pxl_t pxl1;

    video_timer timer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .raster  (raster)
    );

    // Front layer
    tile_layer #(.LAYER(0)) layer0_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .raster   (raster),
        .cpu_wr   (cpu_wr),
        .gfx_addr (gfx0_addr),
        .gfx_cs   (gfx0_cs),
        .gfx_data (gfx0_data),
        .pxl      (pxl0)
    );

    tile_layer #(.LAYER(1)) layer1_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .raster   (raster),
        .cpu_wr   (cpu_wr),
        .gfx_addr (gfx1_addr),
        .gfx_cs   (gfx1_cs),
        .gfx_data (gfx1_data),
        .pxl      (pxl1)
    );

    color_mixer mixer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .raster   (raster),
        .cpu_wr   (cpu_wr),
        .pxl0     (pxl0),
        .pxl1     (pxl1),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl),
        .lvbl_dly (lvbl),
        .hs_dly   (hs),
        .vs_dly   (vs)
    );

endmodule

// File: hw/color_mixer.sv
/*
  Fixed priority, layer 0 in front of layer 1, palette entry 0 as backdrop.
  Palette entry holds red in 11:8, green in 7:4 and blue in 3:0.
  Outputs come one pixel step after the layer pixels, with the raster
  delayed to match, so RGB and the *_dly flags describe the same pixel.
*/
`include "video_defines.svh"

module color_mixer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  video_timing_pkg::raster_t   raster,
    input  video_pixel_pkg::cpu_wr_t    cpu_wr,
    input  video_pixel_pkg::layer_pxl_t pxl0,
    input  video_pixel_pkg::layer_pxl_t pxl1,
    output logic [7:0]                  red,
    output logic [7:0]                  green,
    output logic [7:0]                  blue,
    output logic                        lhbl_dly,
    output logic                        lvbl_dly,
    output logic                        hs_dly,
    output logic                        vs_dly
);
    import video_timing_pkg::*;
    import video_pixel_pkg::*;

    localparam int PAL_ENTRIES  = 256;
    // Layer latency plus the palette read
    localparam int RASTER_DEPTH = `LAYER_LAT + 1;

    logic [11:0] pal_mem [PAL_ENTRIES];
    logic [7:0]  pal_idx;
    logic [11:0] pal_q;
    raster_t     raster_dly;
    logic        visible;

    always_comb begin
        if (pxl0.pen != 4'd0) begin
            pal_idx = {pxl0.pal, pxl0.pen};
        end else if (pxl1.pen != 4'd0) begin
            pal_idx = {pxl1.pal, pxl1.pen};
        end else begin
            // Backdrop
            pal_idx = 8'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_wr.we && cpu_wr.target == palette) begin
            pal_mem[cpu_wr.addr] <= cpu_wr.data[11:0];
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_q <= pal_mem[pal_idx];
        end
    end

    pxl_delay #(
        .payload_t (raster_t),
        .DEPTH     (RASTER_DEPTH)
    ) raster_delay_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .din     (raster),
        .dout    (raster_dly)
    );

    assign lhbl_dly = raster_dly.lhbl;
    assign lvbl_dly = raster_dly.lvbl;
    assign hs_dly   = raster_dly.hs;
    assign vs_dly   = raster_dly.vs;

    assign visible = raster_dly.lhbl && raster_dly.lvbl;

    // Nibble repeated to fill 8 bits, black during blanking
    assign red   = visible ? {2{pal_q[11:8]}} : 8'd0;
    assign green = visible ? {2{pal_q[7:4]}}  : 8'd0;
    assign blue  = visible ? {2{pal_q[3:0]}}  : 8'd0;

    pal_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_wr.we && cpu_wr.target == palette
        |-> !$isunknown(cpu_wr.addr) && int'(cpu_wr.addr) < PAL_ENTRIES);

endmodule

// File: hw/tile_layer.sv
/*
  One scrolling tile layer. Map and scroll are written by the CPU at any time,
  so mid-frame writes show up on the next fetched pixel.
  ROM data must be valid exactly one clk after gfx_cs; there is no wait state.
  Pixel for raster position h leaves LAYER_LAT pixel steps after the timer shows h.
*/
`include "video_defines.svh"

module tile_layer #(
    parameter int LAYER = 0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  video_timing_pkg::raster_t   raster,
    input  video_pixel_pkg::cpu_wr_t    cpu_wr,
    output video_pixel_pkg::gfx_req_t   gfx_addr,
    output logic                        gfx_cs,
    input  logic [31:0]                 gfx_data,
    output video_pixel_pkg::layer_pxl_t pxl
);
    import video_pixel_pkg::*;

    localparam int MAP_SIZE   = `MAP_COLS * `MAP_ROWS;
    localparam int MAP_AW     = $clog2(MAP_SIZE);
    localparam int FINE_W     = $clog2(`TILE_W);
    localparam int SCR_W      = $clog2(`MAP_COLS * `TILE_W);
    // Map read and ROM fetch take two of the LAYER_LAT steps
    localparam int ATTR_DEPTH = `LAYER_LAT - 2;

    localparam cpu_target_e MAP_TGT  = (LAYER == 0) ? map0 : map1;
    localparam logic [7:0]  SCR_ADDR = 8'(2 * LAYER);

    logic [SCR_W-1:0]  hscroll;
    logic [SCR_W-1:0]  vscroll;
    logic [SCR_W-1:0]  sx;
    logic [SCR_W-1:0]  sy;
    logic [MAP_AW-1:0] map_idx;

    // Map entry has the palette in 11:8 and tile code in 7:0
    logic [11:0]       map_mem [MAP_SIZE];
    logic [11:0]       map_q;
    logic [FINE_W-1:0] fine_x_q;
    logic [FINE_W-1:0] fine_y_q;
    tile_attr_t        attr_in;
    tile_attr_t        attr_dly;
    logic [31:0]       row_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hscroll <= '0;
            vscroll <= '0;
        end else if (cpu_wr.we && cpu_wr.target == scroll) begin
            if (cpu_wr.addr == SCR_ADDR) begin
                hscroll <= cpu_wr.data[SCR_W-1:0];
            end
            if (cpu_wr.addr == SCR_ADDR + 8'd1) begin
                vscroll <= cpu_wr.data[SCR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_wr.we && cpu_wr.target == MAP_TGT) begin
            map_mem[cpu_wr.addr[MAP_AW-1:0]] <= cpu_wr.data[11:0];
        end
    end

    // Scroll wraps at 64 pixels through the 6-bit sum
    assign sx      = raster.hdump + hscroll;
    assign sy      = raster.vdump + vscroll;
    assign map_idx = MAP_AW'(sy[SCR_W-1:FINE_W] * `MAP_COLS + sx[SCR_W-1:FINE_W]);

    // Step 1: map read
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            map_q    <= map_mem[map_idx];
            fine_x_q <= sx[FINE_W-1:0];
            fine_y_q <= sy[FINE_W-1:0];
        end
    end

    // ROM request in the clk right after the map read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gfx_cs <= 1'b0;
        end else begin
            gfx_cs <= pxl_cen;
        end
    end

    assign gfx_addr = '{spare: 1'b0, code: map_q[7:0], row: fine_y_q};
    assign attr_in  = '{pal: map_q[11:8], fine_x: fine_x_q};

    pxl_delay #(
        .payload_t (tile_attr_t),
        .DEPTH     (ATTR_DEPTH)
    ) attr_delay_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .din     (attr_in),
        .dout    (attr_dly)
    );

    // Step 2: row arrives one clk after the request, on the next pxl_cen
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            row_q <= gfx_data;
        end
    end

    // Step 3: pick the nibble at fine x
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl.pal <= attr_dly.pal;
            pxl.pen <= row_q[{attr_dly.fine_x, 2'b00} +: 4];
        end
    end

    // One fetch per pixel, so the ROM sees at most every other clk
    gfx_cs_gap_a: assert property (@(posedge clk) disable iff (!rst_n)
        gfx_cs |=> !gfx_cs);

endmodule

// File: hw/pxl_delay.sv
/*
  Delay line of DEPTH pixel steps for any packed payload.
  Shifts only on pxl_cen and clears to zero on reset.
  DEPTH must be at least 1.
*/
`include "video_defines.svh"

module pxl_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pxl_cen,
    input  payload_t din,
    output payload_t dout
);

    payload_t pipe [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else if (pxl_cen) begin
            pipe[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[DEPTH-1];

endmodule

// File: hw/video_timer.sv
/*
  Pixel enable is clk divided by two.
  Counters and flags all move on pxl_cen and are registered together.
  After reset the raster sits at the last pixel of a blank line, all flags low.
*/
`include "video_defines.svh"

module video_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic                      pxl_cen,
    output video_timing_pkg::raster_t raster
);
    import video_timing_pkg::*;

    // Reset position lies inside vertical blank
    localparam raster_t RASTER_RST = '{
        hdump: HDUMP_W'(`H_TOTAL - 1),
        vdump: VDUMP_W'(`V_ACTIVE),
        lhbl:  1'b0,
        lvbl:  1'b0,
        hs:    1'b0,
        vs:    1'b0
    };

    logic [HDUMP_W-1:0] h_nxt;
    logic [VDUMP_W-1:0] v_nxt;
    logic               line_end;

    assign line_end = raster.hdump == HDUMP_W'(`H_TOTAL - 1);

    always_comb begin
        h_nxt = line_end ? '0 : raster.hdump + 1'b1;
        v_nxt = raster.vdump;
        if (line_end) begin
            v_nxt = (raster.vdump == VDUMP_W'(`V_TOTAL - 1)) ? '0 : raster.vdump + 1'b1;
        end
    end

    // Flags decode the next position so they line up with the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
            raster  <= RASTER_RST;
        end else begin
            pxl_cen <= !pxl_cen;
            if (pxl_cen) begin
                raster.hdump <= h_nxt;
                raster.vdump <= v_nxt;
                raster.lhbl  <= int'(h_nxt) < `H_ACTIVE;
                raster.lvbl  <= int'(v_nxt) < `V_ACTIVE;
                raster.hs    <= int'(h_nxt) >= `HS_START
                             && int'(h_nxt) < `HS_START + `HS_LEN;
                raster.vs    <= int'(v_nxt) >= `VS_START
                             && int'(v_nxt) < `VS_START + `VS_LEN;
            end
        end
    end

    // Both counters stay inside the raster totals
    raster_range_a: assert property (@(posedge clk) disable iff (!rst_n)
        int'(raster.hdump) < `H_TOTAL && int'(raster.vdump) < `V_TOTAL);

endmodule

// File: hw/video_pixel_pkg.sv
/*
  CPU write bus, graphics ROM request and per-layer pixel types.
  A CPU write lasts one clk with no acknowledge.
  Pen 0 of a layer pixel is transparent.
*/
`include "video_defines.svh"

package video_pixel_pkg;

    // Which block a CPU write is meant for
    typedef enum logic [1:0] {
        map0    = 2'd0,
        map1    = 2'd1,
        scroll  = 2'd2,
        palette = 2'd3
    } cpu_target_e;

    typedef struct packed {
        logic        we;
        cpu_target_e target;
        logic [7:0]  addr;
        logic [15:0] data;
    } cpu_wr_t;

    // ROM row address, top bit unused
    typedef struct packed {
        logic                          spare;
        logic [7:0]                    code;
        logic [$clog2(`TILE_W)-1:0]    row;
    } gfx_req_t;

    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] pen;
    } layer_pxl_t;

    // Travels beside the ROM fetch until the row comes back
    typedef struct packed {
        logic [3:0]                    pal;
        logic [$clog2(`TILE_W)-1:0]    fine_x;
    } tile_attr_t;

endpackage

// File: hw/video_timing_pkg.sv
/*
  Raster position and blanking as seen by every stage of the pipeline.
  Counter widths follow the raster totals in video_defines.svh.
*/
`include "video_defines.svh"

package video_timing_pkg;

    localparam int HDUMP_W = $clog2(`H_TOTAL);
    localparam int VDUMP_W = $clog2(`V_TOTAL);

    // One raster position with its blanking and sync flags
    typedef struct packed {
        logic [HDUMP_W-1:0] hdump;
        logic [VDUMP_W-1:0] vdump;
        // High inside the visible area
        logic               lhbl;
        logic               lvbl;
        // Sync pulses, active high
        logic               hs;
        logic               vs;
    } raster_t;

endpackage

// File: hw/video_defines.svh
/*
  Raster, sync and tile geometry for the video subsystem.
  The tile layers assume a scroll space of MAP_COLS*TILE_W = 64 pixels.
  H_TOTAL and V_TOTAL must stay at most 64 to fit the 6-bit counters.
*/
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Raster size, total and visible
`define H_TOTAL   64
`define H_ACTIVE  48
`define V_TOTAL   40
`define V_ACTIVE  32

// Sync pulse start and length, in pixels and lines
`define HS_START  52
`define HS_LEN    4
`define VS_START  34
`define VS_LEN    2

// Tile edge and map size in tiles
`define TILE_W    8
`define MAP_COLS  8
`define MAP_ROWS  8

// Pixel steps from timer position to layer output
`define LAYER_LAT 3

`endif
